/* all.f */
+incdir+hw
+incdir+verif
hw/id_pkg.sv
hw/id_decoder.sv
hw/id_operand_mux.sv
hw/id_branch_unit.sv
hw/id_ex_reg.sv
hw/id_stage.sv
verif/id_tb.sv

/* hw/id_branch_unit.sv */
`timescale 1ns/1ps
`include "id_defines.svh"

module id_branch_unit import id_pkg::*; (
	input  logic [`ID_WORD_W-1:0] pc_i,
	input  logic [`ID_WORD_W-1:0] inst_i,
	input  br_cond_e              br_cond_i,
	input  logic                  wreg_i,
	input  logic [`ID_WORD_W-1:0] reg1_i,
	input  logic [`ID_WORD_W-1:0] reg2_i,
	output logic                  branch_flag_o,
	output logic [`ID_WORD_W-1:0] branch_target_o,
	output logic [`ID_WORD_W-1:0] link_addr_o,
	output logic                  wreg_o
);

	logic [`ID_WORD_W-1:0] pc_plus_4;
	logic [`ID_WORD_W-1:0] br_offset;
	logic                  reg1_zero;
	logic                  reg_target;
	logic                  link;

	assign pc_plus_4  = pc_i + 32'd4;
	assign br_offset  = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
	assign reg1_zero  = (reg1_i == '0);
	// JR and JALR sit under SPECIAL, bit 0 of funct marks JALR
	assign reg_target = (inst_i[31:26] == OP_SPECIAL);

	assign link = ((br_cond_i == BR_ALWAYS) &&
		((inst_i[31:26] == OP_JAL) || (reg_target && inst_i[0]))) ||
		(((br_cond_i == BR_LTZ) || (br_cond_i == BR_GEZ)) && inst_i[20]);

	assign link_addr_o = link ? (pc_i + 32'd8) : '0;

	always_comb begin
		case (br_cond_i)
			BR_ALWAYS: branch_flag_o = 1'b1;
			BR_EQ:     branch_flag_o = (reg1_i == reg2_i);
			BR_NE:     branch_flag_o = (reg1_i != reg2_i);
			BR_GTZ:    branch_flag_o = !reg1_i[31] && !reg1_zero;
			BR_LEZ:    branch_flag_o = reg1_i[31] || reg1_zero;
			BR_LTZ:    branch_flag_o = reg1_i[31];
			BR_GEZ:    branch_flag_o = !reg1_i[31];
			default:   branch_flag_o = 1'b0;
		endcase

		if (!branch_flag_o)
			branch_target_o = '0;
		else if (br_cond_i != BR_ALWAYS)
			branch_target_o = pc_plus_4 + br_offset;
		else if (reg_target)
			branch_target_o = reg1_i;
		else
			branch_target_o = {pc_plus_4[31:28], inst_i[25:0], 2'b00};

		// Conditional moves write only when rt passes the test
		case (br_cond_i)
			BR_MOVN: wreg_o = wreg_i && (reg2_i != '0);
			BR_MOVZ: wreg_o = wreg_i && (reg2_i == '0);
			default: wreg_o = wreg_i;
		endcase
	end

endmodule

/* hw/id_decoder.sv */
`timescale 1ns/1ps
`include "id_defines.svh"

module id_decoder import id_pkg::*; (
	input  logic [`ID_WORD_W-1:0]     inst_i,
	output aluop_e                    aluop_o,
	output alusel_e                   alusel_o,
	output br_cond_e                  br_cond_o,
	output logic [`ID_REG_ADDR_W-1:0] wd_o,
	output logic                      wreg_o,
	output logic [`ID_REG_ADDR_W-1:0] reg1_addr_o,
	output logic [`ID_REG_ADDR_W-1:0] reg2_addr_o,
	output logic                      reg1_en_o,
	output logic                      reg2_en_o,
	output logic [`ID_WORD_W-1:0]     imm_o
);

	// SPECIAL function field
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_SRA  = 6'b000011;
	localparam logic [5:0] FN_SLLV = 6'b000100;
	localparam logic [5:0] FN_SRLV = 6'b000110;
	localparam logic [5:0] FN_SRAV = 6'b000111;
	localparam logic [5:0] FN_JR   = 6'b001000;
	localparam logic [5:0] FN_JALR = 6'b001001;
	localparam logic [5:0] FN_MOVZ = 6'b001010;
	localparam logic [5:0] FN_MOVN = 6'b001011;
	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

	opcode_e                   opcode;
	logic [`ID_REG_ADDR_W-1:0] rs;
	logic [`ID_REG_ADDR_W-1:0] rt;
	logic [`ID_REG_ADDR_W-1:0] rd;
	logic [`ID_REG_ADDR_W-1:0] shamt;
	logic [5:0]                funct;
	logic [15:0]               imm16;
	logic                      shift_imm;

	assign opcode = opcode_e'(inst_i[31:26]);
	assign rs     = inst_i[25:21];
	assign rt     = inst_i[20:16];
	assign rd     = inst_i[15:11];
	assign shamt  = inst_i[10:6];
	assign funct  = inst_i[5:0];
	assign imm16  = inst_i[15:0];

	assign shift_imm = (funct == FN_SLL) || (funct == FN_SRL) || (funct == FN_SRA);

	// Register file is always addressed by rs and rt
	assign reg1_addr_o = rs;
	assign reg2_addr_o = rt;

	always_comb begin
		aluop_o   = ALU_NOP;
		wd_o      = `ID_ZERO_REG;
		wreg_o    = 1'b0;
		reg1_en_o = 1'b0;
		reg2_en_o = 1'b0;
		imm_o     = '0;
		case (opcode)
			OP_SPECIAL: begin
				case (funct)
					FN_AND:           aluop_o = ALU_AND;
					FN_OR:            aluop_o = ALU_OR;
					FN_XOR:           aluop_o = ALU_XOR;
					FN_NOR:           aluop_o = ALU_NOR;
					FN_SLL, FN_SLLV:  aluop_o = ALU_SLL;
					FN_SRL, FN_SRLV:  aluop_o = ALU_SRL;
					FN_SRA, FN_SRAV:  aluop_o = ALU_SRA;
					FN_ADD:           aluop_o = ALU_ADD;
					FN_ADDU:          aluop_o = ALU_ADDU;
					FN_SUB:           aluop_o = ALU_SUB;
					FN_SUBU:          aluop_o = ALU_SUBU;
					FN_SLT:           aluop_o = ALU_SLT;
					FN_SLTU:          aluop_o = ALU_SLTU;
					FN_MOVN:          aluop_o = ALU_MOVN;
					FN_MOVZ:          aluop_o = ALU_MOVZ;
					FN_JR:            aluop_o = ALU_JR;
					FN_JALR:          aluop_o = ALU_JALR;
					default:          aluop_o = ALU_NOP;
				endcase
				// Immediate shifts need rs clear, the rest need shamt clear
				if (shift_imm ? (rs != 5'd0) : (shamt != 5'd0))
					aluop_o = ALU_NOP;
				if (aluop_o != ALU_NOP) begin
					wd_o      = rd;
					wreg_o    = (funct != FN_JR);
					reg1_en_o = !shift_imm;
					reg2_en_o = (funct != FN_JR) && (funct != FN_JALR);
					if (shift_imm)
						imm_o = {27'h0, shamt};
				end
			end
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				wd_o      = rt;
				wreg_o    = 1'b1;
				// LUI ORs the shifted immediate with itself
				reg1_en_o = (opcode != OP_LUI);
				imm_o     = {{16{imm16[15]}}, imm16};
				case (opcode)
					OP_ANDI:  aluop_o = ALU_AND;
					OP_ORI:   aluop_o = ALU_OR;
					OP_XORI:  aluop_o = ALU_XOR;
					OP_LUI:   aluop_o = ALU_OR;
					OP_ADDI:  aluop_o = ALU_ADDI;
					OP_ADDIU: aluop_o = ALU_ADDIU;
					OP_SLTI:  aluop_o = ALU_SLT;
					default:  aluop_o = ALU_SLTU;
				endcase
				if (opcode inside {OP_ANDI, OP_ORI, OP_XORI})
					imm_o = {16'h0, imm16};
				else if (opcode == OP_LUI)
					imm_o = {imm16, 16'h0};
			end
			OP_J: aluop_o = ALU_J;
			OP_JAL: begin
				aluop_o = ALU_JAL;
				wd_o    = `ID_LINK_REG;
				wreg_o  = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				aluop_o   = (opcode == OP_BEQ) ? ALU_BEQ : ALU_BNE;
				reg1_en_o = 1'b1;
				reg2_en_o = 1'b1;
			end
			OP_BGTZ, OP_BLEZ: begin
				aluop_o   = (opcode == OP_BGTZ) ? ALU_BGTZ : ALU_BLEZ;
				reg1_en_o = 1'b1;
			end
			OP_REGIMM: begin
				case (rt)
					5'b00000: aluop_o = ALU_BLTZ;
					5'b00001: aluop_o = ALU_BGEZ;
					5'b10000: aluop_o = ALU_BLTZAL;
					5'b10001: aluop_o = ALU_BGEZAL;
					default:  aluop_o = ALU_NOP;
				endcase
				reg1_en_o = (aluop_o != ALU_NOP);
				// Linking forms always write r31
				if (rt[4] && reg1_en_o) begin
					wd_o   = `ID_LINK_REG;
					wreg_o = 1'b1;
				end
			end
			OP_LW: begin
				aluop_o   = ALU_LW;
				wd_o      = rt;
				wreg_o    = 1'b1;
				reg1_en_o = 1'b1;
			end
			OP_SW: begin
				aluop_o   = ALU_SW;
				reg1_en_o = 1'b1;
				reg2_en_o = 1'b1;
			end
			// SYNC and PREF land here as NOP
			default: ;
		endcase
	end

	////////////////////////////////////////////////////
	// Result class and branch condition from aluop
	////////////////////////////////////////////////////

	always_comb begin
		case (aluop_o)
			ALU_NOP:                                alusel_o = SEL_NOP;
			ALU_AND, ALU_OR, ALU_XOR, ALU_NOR:      alusel_o = SEL_LOGIC;
			ALU_SLL, ALU_SRL, ALU_SRA:              alusel_o = SEL_SHIFT;
			ALU_MOVN, ALU_MOVZ:                     alusel_o = SEL_MOVE;
			ALU_LW, ALU_SW:                         alusel_o = SEL_LOAD_STORE;
			ALU_J, ALU_JAL, ALU_JR, ALU_JALR, ALU_BEQ, ALU_BNE, ALU_BGTZ, ALU_BLEZ,
			ALU_BLTZ, ALU_BGEZ, ALU_BLTZAL, ALU_BGEZAL: alusel_o = SEL_JUMP_BRANCH;
			default:                                alusel_o = SEL_ARITH;
		endcase
		case (aluop_o)
			ALU_J, ALU_JAL, ALU_JR, ALU_JALR: br_cond_o = BR_ALWAYS;
			ALU_BEQ:                          br_cond_o = BR_EQ;
			ALU_BNE:                          br_cond_o = BR_NE;
			ALU_BGTZ:                         br_cond_o = BR_GTZ;
			ALU_BLEZ:                         br_cond_o = BR_LEZ;
			ALU_BLTZ, ALU_BLTZAL:             br_cond_o = BR_LTZ;
			ALU_BGEZ, ALU_BGEZAL:             br_cond_o = BR_GEZ;
			ALU_MOVN:                         br_cond_o = BR_MOVN;
			ALU_MOVZ:                         br_cond_o = BR_MOVZ;
			default:                          br_cond_o = BR_NONE;
		endcase
	end

endmodule

/* hw/id_defines.svh */
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

////////////////////////////////////////////////////
// Datapath and register file widths
////////////////////////////////////////////////////

`define ID_WORD_W      32
`define ID_REG_ADDR_W  5

// Fixed register numbers
`define ID_LINK_REG    5'd31
`define ID_ZERO_REG    5'd0

`endif

/* hw/id_ex_reg.sv */
`timescale 1ns/1ps
`include "id_defines.svh"

module id_ex_reg import id_pkg::*; (
	input  logic                      clk_i,
	input  logic                      arst_n_i,
	input  logic                      stall_i,
	input  aluop_e                    aluop_i,
	input  alusel_e                   alusel_i,
	input  logic [`ID_WORD_W-1:0]     reg1_i,
	input  logic [`ID_WORD_W-1:0]     reg2_i,
	input  logic [`ID_REG_ADDR_W-1:0] wd_i,
	input  logic                      wreg_i,
	input  logic [`ID_WORD_W-1:0]     link_addr_i,
	input  logic [`ID_WORD_W-1:0]     branch_target_i,
	input  logic                      branch_flag_i,
	input  logic [`ID_WORD_W-1:0]     inst_i,
	output aluop_e                    aluop_o,
	output alusel_e                   alusel_o,
	output logic [`ID_WORD_W-1:0]     reg1_o,
	output logic [`ID_WORD_W-1:0]     reg2_o,
	output logic [`ID_REG_ADDR_W-1:0] wd_o,
	output logic                      wreg_o,
	output logic [`ID_WORD_W-1:0]     link_addr_o,
	output logic [`ID_WORD_W-1:0]     branch_target_o,
	output logic                      branch_flag_o,
	output logic                      in_delay_slot_o,
	output logic [`ID_WORD_W-1:0]     inst_o
);

	// Set once a taken branch is captured, held until its slot arrives
	logic next_in_delay_slot;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			aluop_o            <= ALU_NOP;
			alusel_o           <= SEL_NOP;
			reg1_o             <= '0;
			reg2_o             <= '0;
			wd_o               <= `ID_ZERO_REG;
			wreg_o             <= 1'b0;
			link_addr_o        <= '0;
			branch_target_o    <= '0;
			branch_flag_o      <= 1'b0;
			inst_o             <= '0;
			in_delay_slot_o    <= 1'b0;
			next_in_delay_slot <= 1'b0;
		end else begin
			// A stall turns the captured instruction into a bubble
			aluop_o         <= stall_i ? ALU_NOP : aluop_i;
			alusel_o        <= stall_i ? SEL_NOP : alusel_i;
			reg1_o          <= stall_i ? '0 : reg1_i;
			reg2_o          <= stall_i ? '0 : reg2_i;
			wd_o            <= stall_i ? `ID_ZERO_REG : wd_i;
			wreg_o          <= !stall_i && wreg_i;
			link_addr_o     <= stall_i ? '0 : link_addr_i;
			branch_target_o <= stall_i ? '0 : branch_target_i;
			branch_flag_o   <= !stall_i && branch_flag_i;
			inst_o          <= stall_i ? '0 : inst_i;
			if (!stall_i) begin
				in_delay_slot_o    <= next_in_delay_slot;
				next_in_delay_slot <= branch_flag_i;
			end
		end
	end

endmodule

/* hw/id_operand_mux.sv */
`timescale 1ns/1ps
`include "id_defines.svh"

module id_operand_mux import id_pkg::*; (
	input  logic                      read_en_i,
	input  logic [`ID_REG_ADDR_W-1:0] read_addr_i,
	input  logic [`ID_WORD_W-1:0]     imm_i,
	input  logic [`ID_WORD_W-1:0]     rf_data_i,
	input  logic                      ex_wreg_i,
	input  logic [`ID_REG_ADDR_W-1:0] ex_wd_i,
	input  logic [`ID_WORD_W-1:0]     ex_wdata_i,
	input  aluop_e                    ex_aluop_i,
	input  logic                      mem_wreg_i,
	input  logic [`ID_REG_ADDR_W-1:0] mem_wd_i,
	input  logic [`ID_WORD_W-1:0]     mem_wdata_i,
	output logic [`ID_WORD_W-1:0]     operand_o,
	output logic                      stall_o
);

	logic ex_match;
	logic ex_hit;
	logic mem_hit;

	assign ex_match = (ex_wd_i == read_addr_i);
	assign ex_hit   = ex_wreg_i && ex_match;
	assign mem_hit  = mem_wreg_i && (mem_wd_i == read_addr_i);

	// Load data is not ready until MEM, so the consumer waits a cycle
	assign stall_o = read_en_i && ex_match && (ex_aluop_i == ALU_LW);

	always_comb begin
		if (!read_en_i)
			operand_o = imm_i;
		else if (stall_o)
			operand_o = '0;
		else if (ex_hit)
			operand_o = ex_wdata_i;
		else if (mem_hit)
			operand_o = mem_wdata_i;
		else
			operand_o = rf_data_i;
	end

endmodule

/* hw/id_pkg.sv */
package id_pkg;

	// Operation handed to EX, encoding shared with the EX stage
	typedef enum logic [7:0] {
		ALU_NOP    = 8'b0000_0000,
		ALU_AND    = 8'b0010_0100,
		ALU_OR     = 8'b0010_0101,
		ALU_XOR    = 8'b0010_0110,
		ALU_NOR    = 8'b0010_0111,
		ALU_SLL    = 8'b0111_1100,
		ALU_SRL    = 8'b0000_0010,
		ALU_SRA    = 8'b0000_0011,
		ALU_MOVZ   = 8'b0000_1010,
		ALU_MOVN   = 8'b0000_1011,
		ALU_SLT    = 8'b0010_1010,
		ALU_SLTU   = 8'b0010_1011,
		ALU_ADD    = 8'b0010_0000,
		ALU_ADDU   = 8'b0010_0001,
		ALU_SUB    = 8'b0010_0010,
		ALU_SUBU   = 8'b0010_0011,
		ALU_ADDI   = 8'b0101_0101,
		ALU_ADDIU  = 8'b0101_0110,
		ALU_J      = 8'b0100_1111,
		ALU_JAL    = 8'b0101_0000,
		ALU_JR     = 8'b0000_1000,
		ALU_JALR   = 8'b0000_1001,
		ALU_BEQ    = 8'b0101_0001,
		ALU_BNE    = 8'b0101_0010,
		ALU_BGTZ   = 8'b0101_0100,
		ALU_BLEZ   = 8'b0101_0011,
		ALU_BLTZ   = 8'b0100_0000,
		ALU_BGEZ   = 8'b0100_0001,
		ALU_BLTZAL = 8'b0100_1010,
		ALU_BGEZAL = 8'b0100_1011,
		ALU_LW     = 8'b1110_0011,
		ALU_SW     = 8'b1110_1011
	} aluop_e;

	// Result class selects the EX output path
	typedef enum logic [2:0] {
		SEL_NOP         = 3'b000,
		SEL_LOGIC       = 3'b001,
		SEL_SHIFT       = 3'b010,
		SEL_MOVE        = 3'b011,
		SEL_ARITH       = 3'b100,
		SEL_JUMP_BRANCH = 3'b110,
		SEL_LOAD_STORE  = 3'b111
	} alusel_e;

	typedef enum logic [3:0] {
		BR_NONE,
		BR_ALWAYS,
		BR_EQ,
		BR_NE,
		BR_GTZ,
		BR_LEZ,
		BR_LTZ,
		BR_GEZ,
		BR_MOVN,
		BR_MOVZ
	} br_cond_e;

	// Primary opcode field, inst[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_REGIMM  = 6'b000001,
		OP_J       = 6'b000010,
		OP_JAL     = 6'b000011,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_BLEZ    = 6'b000110,
		OP_BGTZ    = 6'b000111,
		OP_ADDI    = 6'b001000,
		OP_ADDIU   = 6'b001001,
		OP_SLTI    = 6'b001010,
		OP_SLTIU   = 6'b001011,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111,
		OP_LW      = 6'b100011,
		OP_SW      = 6'b101011
	} opcode_e;

endpackage

/* hw/id_stage.sv */
`timescale 1ns/1ps
`include "id_defines.svh"

module id_stage import id_pkg::*; (
	input  logic                      clk_i,
	input  logic                      arst_n_i,
	input  logic [`ID_WORD_W-1:0]     pc_i,
	input  logic [`ID_WORD_W-1:0]     inst_i,
	input  logic [`ID_WORD_W-1:0]     reg1_data_i,
	input  logic [`ID_WORD_W-1:0]     reg2_data_i,
	input  logic                      ex_wreg_i,
	input  logic [`ID_REG_ADDR_W-1:0] ex_wd_i,
	input  logic [`ID_WORD_W-1:0]     ex_wdata_i,
	input  aluop_e                    ex_aluop_i,
	input  logic                      mem_wreg_i,
	input  logic [`ID_REG_ADDR_W-1:0] mem_wd_i,
	input  logic [`ID_WORD_W-1:0]     mem_wdata_i,
	output logic [`ID_REG_ADDR_W-1:0] reg1_addr_o,
	output logic [`ID_REG_ADDR_W-1:0] reg2_addr_o,
	output logic                      stall_o,
	output aluop_e                    aluop_o,
	output alusel_e                   alusel_o,
	output logic [`ID_WORD_W-1:0]     reg1_o,
	output logic [`ID_WORD_W-1:0]     reg2_o,
	output logic [`ID_REG_ADDR_W-1:0] wd_o,
	output logic                      wreg_o,
	output logic [`ID_WORD_W-1:0]     link_addr_o,
	output logic [`ID_WORD_W-1:0]     branch_target_o,
	output logic                      branch_flag_o,
	output logic                      in_delay_slot_o,
	output logic [`ID_WORD_W-1:0]     inst_o
);

	aluop_e                    dec_aluop;
	alusel_e                   dec_alusel;
	br_cond_e                  dec_br_cond;
	logic [`ID_REG_ADDR_W-1:0] dec_wd;
	logic                      dec_wreg;
	logic                      reg1_en;
	logic                      reg2_en;
	logic [`ID_WORD_W-1:0]     imm;
	logic [`ID_WORD_W-1:0]     opnd1;
	logic [`ID_WORD_W-1:0]     opnd2;
	logic                      stall1;
	logic                      stall2;
	logic                      br_flag;
	logic [`ID_WORD_W-1:0]     br_target;
	logic [`ID_WORD_W-1:0]     link_addr;
	logic                      final_wreg;

	assign stall_o = stall1 | stall2;

	id_decoder u_decoder (
		.inst_i      (inst_i),
		.aluop_o     (dec_aluop),
		.alusel_o    (dec_alusel),
		.br_cond_o   (dec_br_cond),
		.wd_o        (dec_wd),
		.wreg_o      (dec_wreg),
		.reg1_addr_o (reg1_addr_o),
		.reg2_addr_o (reg2_addr_o),
		.reg1_en_o   (reg1_en),
		.reg2_en_o   (reg2_en),
		.imm_o       (imm)
	);

	//////////////////////////////////////////////////
	// Operand resolution, one mux per source
	//////////////////////////////////////////////////

	id_operand_mux u_op1_mux (
		.read_en_i   (reg1_en),
		.read_addr_i (reg1_addr_o),
		.imm_i       (imm),
		.rf_data_i   (reg1_data_i),
		.ex_wreg_i   (ex_wreg_i),
		.ex_wd_i     (ex_wd_i),
		.ex_wdata_i  (ex_wdata_i),
		.ex_aluop_i  (ex_aluop_i),
		.mem_wreg_i  (mem_wreg_i),
		.mem_wd_i    (mem_wd_i),
		.mem_wdata_i (mem_wdata_i),
		.operand_o   (opnd1),
		.stall_o     (stall1)
	);

	id_operand_mux u_op2_mux (
		.read_en_i   (reg2_en),
		.read_addr_i (reg2_addr_o),
		.imm_i       (imm),
		.rf_data_i   (reg2_data_i),
		.ex_wreg_i   (ex_wreg_i),
		.ex_wd_i     (ex_wd_i),
		.ex_wdata_i  (ex_wdata_i),
		.ex_aluop_i  (ex_aluop_i),
		.mem_wreg_i  (mem_wreg_i),
		.mem_wd_i    (mem_wd_i),
		.mem_wdata_i (mem_wdata_i),
		.operand_o   (opnd2),
		.stall_o     (stall2)
	);

	id_branch_unit u_branch (
		.pc_i            (pc_i),
		.inst_i          (inst_i),
		.br_cond_i       (dec_br_cond),
		.wreg_i          (dec_wreg),
		.reg1_i          (opnd1),
		.reg2_i          (opnd2),
		.branch_flag_o   (br_flag),
		.branch_target_o (br_target),
		.link_addr_o     (link_addr),
		.wreg_o          (final_wreg)
	);

	id_ex_reg u_id_ex (
		.clk_i           (clk_i),
		.arst_n_i        (arst_n_i),
		.stall_i         (stall_o),
		.aluop_i         (dec_aluop),
		.alusel_i        (dec_alusel),
		.reg1_i          (opnd1),
		.reg2_i          (opnd2),
		.wd_i            (dec_wd),
		.wreg_i          (final_wreg),
		.link_addr_i     (link_addr),
		.branch_target_i (br_target),
		.branch_flag_i   (br_flag),
		.inst_i          (inst_i),
		.aluop_o         (aluop_o),
		.alusel_o        (alusel_o),
		.reg1_o          (reg1_o),
		.reg2_o          (reg2_o),
		.wd_o            (wd_o),
		.wreg_o          (wreg_o),
		.link_addr_o     (link_addr_o),
		.branch_target_o (branch_target_o),
		.branch_flag_o   (branch_flag_o),
		.in_delay_slot_o (in_delay_slot_o),
		.inst_o          (inst_o)
	);

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --top-module id_tb -f all.f --Mdir obj_dir -o id_sim
./obj_dir/id_sim | tee sim.log

if grep -q "^TEST RESULT: PASS$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi

/* verif/id_model.svh */
`ifndef ID_MODEL_SVH
`define ID_MODEL_SVH

////////////////////////////////////////////////////
// Reference model of the decode stage
////////////////////////////////////////////////////

typedef struct packed {
	aluop_e      aluop;
	logic [4:0]  wd;
	logic        wreg;
	logic        en1;
	logic        en2;
	logic [31:0] imm;
} dec_t;

typedef struct packed {
	logic        taken;
	logic [31:0] target;
	logic [31:0] link;
	logic        wreg;
} br_t;

function automatic dec_t decode_inst(logic [31:0] inst);
	dec_t       d;
	logic [5:0] fn;
	logic       shamt_form;
	fn         = inst[5:0];
	shamt_form = (fn == 6'h00) || (fn == 6'h02) || (fn == 6'h03);
	d          = '0;
	if (inst[31:26] == OP_SPECIAL) begin
		case (fn)
			6'h00, 6'h04: d.aluop = ALU_SLL;
			6'h02, 6'h06: d.aluop = ALU_SRL;
			6'h03, 6'h07: d.aluop = ALU_SRA;
			6'h08:        d.aluop = ALU_JR;
			6'h09:        d.aluop = ALU_JALR;
			6'h0a:        d.aluop = ALU_MOVZ;
			6'h0b:        d.aluop = ALU_MOVN;
			6'h20:        d.aluop = ALU_ADD;
			6'h21:        d.aluop = ALU_ADDU;
			6'h22:        d.aluop = ALU_SUB;
			6'h23:        d.aluop = ALU_SUBU;
			6'h24:        d.aluop = ALU_AND;
			6'h25:        d.aluop = ALU_OR;
			6'h26:        d.aluop = ALU_XOR;
			6'h27:        d.aluop = ALU_NOR;
			6'h2a:        d.aluop = ALU_SLT;
			6'h2b:        d.aluop = ALU_SLTU;
			default:      d.aluop = ALU_NOP;
		endcase
		// Unused field must be zero, rs for shamt shifts and shamt otherwise
		if (shamt_form ? (inst[25:21] != 5'd0) : (inst[10:6] != 5'd0))
			d.aluop = ALU_NOP;
		if (d.aluop != ALU_NOP) begin
			d.wd   = inst[15:11];
			d.wreg = (d.aluop != ALU_JR);
			d.en1  = !shamt_form;
			d.en2  = !(d.aluop inside {ALU_JR, ALU_JALR});
			d.imm  = shamt_form ? {27'd0, inst[10:6]} : 32'd0;
		end
		return d;
	end
	case (inst[31:26])
		OP_ANDI:   d.aluop = ALU_AND;
		OP_ORI:    d.aluop = ALU_OR;
		OP_XORI:   d.aluop = ALU_XOR;
		OP_LUI:    d.aluop = ALU_OR;
		OP_ADDI:   d.aluop = ALU_ADDI;
		OP_ADDIU:  d.aluop = ALU_ADDIU;
		OP_SLTI:   d.aluop = ALU_SLT;
		OP_SLTIU:  d.aluop = ALU_SLTU;
		OP_J:      d.aluop = ALU_J;
		OP_JAL:    d.aluop = ALU_JAL;
		OP_BEQ:    d.aluop = ALU_BEQ;
		OP_BNE:    d.aluop = ALU_BNE;
		OP_BLEZ:   d.aluop = ALU_BLEZ;
		OP_BGTZ:   d.aluop = ALU_BGTZ;
		OP_LW:     d.aluop = ALU_LW;
		OP_SW:     d.aluop = ALU_SW;
		OP_REGIMM: begin
			case (inst[20:16])
				5'h00:   d.aluop = ALU_BLTZ;
				5'h01:   d.aluop = ALU_BGEZ;
				5'h10:   d.aluop = ALU_BLTZAL;
				5'h11:   d.aluop = ALU_BGEZAL;
				default: d.aluop = ALU_NOP;
			endcase
		end
		default: ;
	endcase
	// Immediate ALU forms write rt
	if (inst[31:29] == 3'b001) begin
		d.wd   = inst[20:16];
		d.wreg = 1'b1;
		d.en1  = (inst[31:26] != OP_LUI);
		if (inst[31:26] == OP_LUI)
			d.imm = {inst[15:0], 16'h0};
		else if (inst[28])
			d.imm = {16'h0, inst[15:0]};
		else
			d.imm = {{16{inst[15]}}, inst[15:0]};
	end
	case (d.aluop)
		ALU_JAL: begin
			d.wd   = `ID_LINK_REG;
			d.wreg = 1'b1;
		end
		ALU_BLTZAL, ALU_BGEZAL: begin
			d.wd   = `ID_LINK_REG;
			d.wreg = 1'b1;
			d.en1  = 1'b1;
		end
		ALU_BLTZ, ALU_BGEZ, ALU_BGTZ, ALU_BLEZ: d.en1 = 1'b1;
		ALU_BEQ, ALU_BNE, ALU_SW: begin
			d.en1 = 1'b1;
			d.en2 = 1'b1;
		end
		ALU_LW: begin
			d.wd   = inst[20:16];
			d.wreg = 1'b1;
			d.en1  = 1'b1;
		end
		default: ;
	endcase
	return d;
endfunction

function automatic alusel_e class_of(aluop_e op);
	if (op == ALU_NOP)
		return SEL_NOP;
	if (op inside {ALU_AND, ALU_OR, ALU_XOR, ALU_NOR})
		return SEL_LOGIC;
	if (op inside {ALU_SLL, ALU_SRL, ALU_SRA})
		return SEL_SHIFT;
	if (op inside {ALU_MOVN, ALU_MOVZ})
		return SEL_MOVE;
	if (op inside {ALU_LW, ALU_SW})
		return SEL_LOAD_STORE;
	if (op inside {ALU_J, ALU_JAL, ALU_JR, ALU_JALR, ALU_BEQ, ALU_BNE, ALU_BGTZ,
			ALU_BLEZ, ALU_BLTZ, ALU_BGEZ, ALU_BLTZAL, ALU_BGEZAL})
		return SEL_JUMP_BRANCH;
	return SEL_ARITH;
endfunction

// Returns {stall, value}, bypass sources are the driven EX and MEM inputs
function automatic logic [32:0] resolve_operand(
	logic        en,
	logic [4:0]  addr,
	logic [31:0] imm,
	logic [31:0] rf
);
	if (!en)
		return {1'b0, imm};
	if ((ex_aluop_i == ALU_LW) && (ex_wd_i == addr))
		return {1'b1, 32'd0};
	if (ex_wreg_i && (ex_wd_i == addr))
		return {1'b0, ex_wdata_i};
	if (mem_wreg_i && (mem_wd_i == addr))
		return {1'b0, mem_wdata_i};
	return {1'b0, rf};
endfunction

function automatic br_t resolve_branch(
	logic [31:0] pc,
	logic [31:0] inst,
	dec_t        d,
	logic [31:0] a,
	logic [31:0] b
);
	br_t         r;
	logic [31:0] seq;
	seq    = pc + 32'd4;
	r      = '0;
	r.wreg = d.wreg;
	case (d.aluop)
		ALU_J, ALU_JAL, ALU_JR, ALU_JALR: r.taken = 1'b1;
		ALU_BEQ:              r.taken = (a == b);
		ALU_BNE:              r.taken = (a != b);
		ALU_BGTZ:             r.taken = ($signed(a) > 32'sd0);
		ALU_BLEZ:             r.taken = ($signed(a) <= 32'sd0);
		ALU_BLTZ, ALU_BLTZAL: r.taken = ($signed(a) < 32'sd0);
		ALU_BGEZ, ALU_BGEZAL: r.taken = ($signed(a) >= 32'sd0);
		ALU_MOVN:             r.wreg  = d.wreg && (b != 32'd0);
		ALU_MOVZ:             r.wreg  = d.wreg && (b == 32'd0);
		default: ;
	endcase
	// Direct jumps stay inside the 256 MB region of PC+4
	if (d.aluop inside {ALU_JR, ALU_JALR})
		r.target = a;
	else if (d.aluop inside {ALU_J, ALU_JAL})
		r.target = {seq[31:28], inst[25:0], 2'b00};
	else if (r.taken)
		r.target = seq + {{14{inst[15]}}, inst[15:0], 2'b00};
	if (d.aluop inside {ALU_JAL, ALU_JALR, ALU_BLTZAL, ALU_BGEZAL})
		r.link = pc + 32'd8;
	return r;
endfunction

`endif

/* verif/id_tb.sv */
`timescale 1ns/1ps
`include "id_defines.svh"

module id_tb import id_pkg::*; ();

	localparam int RESET_CYCLES = 5;
	localparam int RAND_CYCLES  = 2000;
	localparam int CYCLE_LIMIT  = RESET_CYCLES + RAND_CYCLES + 100;

	// Kept SPECIAL functions
	localparam logic [5:0] FUNCTS [20] = '{
		6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09, 6'h0a, 6'h0b,
		6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b
	};
	localparam opcode_e OPCODES [16] = '{
		OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_ADDI, OP_ADDIU,
		OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW, OP_SW
	};
	localparam logic [4:0] REGIMM_RT [4] = '{5'h00, 5'h01, 5'h10, 5'h11};

	logic                      clk_i;
	logic                      arst_n_i;
	logic [`ID_WORD_W-1:0]     pc_i;
	logic [`ID_WORD_W-1:0]     inst_i;
	logic [`ID_WORD_W-1:0]     reg1_data_i;
	logic [`ID_WORD_W-1:0]     reg2_data_i;
	logic                      ex_wreg_i;
	logic [`ID_REG_ADDR_W-1:0] ex_wd_i;
	logic [`ID_WORD_W-1:0]     ex_wdata_i;
	aluop_e                    ex_aluop_i;
	logic                      mem_wreg_i;
	logic [`ID_REG_ADDR_W-1:0] mem_wd_i;
	logic [`ID_WORD_W-1:0]     mem_wdata_i;
	logic [`ID_REG_ADDR_W-1:0] reg1_addr_o;
	logic [`ID_REG_ADDR_W-1:0] reg2_addr_o;
	logic                      stall_o;
	aluop_e                    aluop_o;
	alusel_e                   alusel_o;
	logic [`ID_WORD_W-1:0]     reg1_o;
	logic [`ID_WORD_W-1:0]     reg2_o;
	logic [`ID_REG_ADDR_W-1:0] wd_o;
	logic                      wreg_o;
	logic [`ID_WORD_W-1:0]     link_addr_o;
	logic [`ID_WORD_W-1:0]     branch_target_o;
	logic                      branch_flag_o;
	logic                      in_delay_slot_o;
	logic [`ID_WORD_W-1:0]     inst_o;

	// Expected ID/EX contents after the next edge
	aluop_e      exp_aluop;
	alusel_e     exp_alusel;
	logic [31:0] exp_reg1;
	logic [31:0] exp_reg2;
	logic [4:0]  exp_wd;
	logic        exp_wreg;
	logic [31:0] exp_link;
	logic [31:0] exp_target;
	logic        exp_flag;
	logic        exp_ds;
	logic [31:0] exp_inst;
	logic        prev_taken;
	logic        cap_stall;
	int          error_count = 0;
	int          check_count = 0;
	int          cycle_count = 0;

	`include "id_model.svh"

	id_stage dut_i (.*);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("ERROR: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic check_value(string test_name, string field, logic [31:0] exp,
			logic [31:0] act);
		check_count++;
		if (exp !== act) begin
			error_count++;
			$display("FAIL %s %s: expected %h, actual %h (cycle %0d)",
				test_name, field, exp, act, cycle_count);
		end
	endtask

	task automatic check_registered(string dec_name, string op_name, string br_name);
		check_value(dec_name, "aluop_o", 32'(exp_aluop), 32'(aluop_o));
		check_value(dec_name, "alusel_o", 32'(exp_alusel), 32'(alusel_o));
		check_value(dec_name, "wd_o", 32'(exp_wd), 32'(wd_o));
		check_value(dec_name, "wreg_o", 32'(exp_wreg), 32'(wreg_o));
		check_value(dec_name, "inst_o", exp_inst, inst_o);
		check_value(op_name, "reg1_o", exp_reg1, reg1_o);
		check_value(op_name, "reg2_o", exp_reg2, reg2_o);
		check_value(br_name, "branch_flag_o", 32'(exp_flag), 32'(branch_flag_o));
		check_value(br_name, "branch_target_o", exp_target, branch_target_o);
		check_value(br_name, "link_addr_o", exp_link, link_addr_o);
		check_value("delay_slot", "in_delay_slot_o", 32'(exp_ds), 32'(in_delay_slot_o));
	endtask

	task automatic load_bubble();
		exp_aluop  = ALU_NOP;
		exp_alusel = SEL_NOP;
		exp_reg1   = '0;
		exp_reg2   = '0;
		exp_wd     = '0;
		exp_wreg   = 1'b0;
		exp_link   = '0;
		exp_target = '0;
		exp_flag   = 1'b0;
		exp_inst   = '0;
	endtask

	////////////////////////////////////////////////////
	// Random stimulus
	////////////////////////////////////////////////////

	// Small register pool so sources and destinations collide often
	function automatic logic [4:0] small_reg();
		if (($urandom % 2) != 0)
			return 5'($urandom % 4);
		return 5'($urandom);
	endfunction

	function automatic logic [4:0] near_reg();
		case ($urandom % 4)
			0:       return inst_i[25:21];
			1:       return inst_i[20:16];
			2:       return 5'($urandom % 4);
			default: return 5'($urandom);
		endcase
	endfunction

	// Zero now and then so the zero compares and MOVZ see both outcomes
	function automatic logic [31:0] random_data();
		if (($urandom % 8) == 0)
			return 32'd0;
		return $urandom;
	endfunction

	function automatic logic [31:0] random_inst();
		logic [31:0] w;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [5:0]  f;
		int unsigned pick;
		w    = $urandom;
		rs   = small_reg();
		rt   = small_reg();
		pick = $urandom % 16;
		if (pick < 7) begin
			f = FUNCTS[5'($urandom % 20)];
			if (f inside {6'h00, 6'h02, 6'h03})
				return {11'd0, rt, w[15:11], w[10:6], f};
			return {6'd0, rs, rt, w[15:11], 5'd0, f};
		end
		if (pick < 12)
			return {OPCODES[4'($urandom)], rs, rt, w[15:0]};
		if (pick < 15)
			return {OP_REGIMM, rs, REGIMM_RT[2'($urandom)], w[15:0]};
		// Raw word, mostly unrecognised
		return w;
	endfunction

	task automatic drive_random();
		inst_i      = random_inst();
		pc_i        = $urandom & 32'hffff_fffc;
		reg1_data_i = random_data();
		reg2_data_i = random_data();
		ex_wreg_i   = ($urandom % 4) != 0;
		ex_wd_i     = near_reg();
		ex_wdata_i  = random_data();
		mem_wreg_i  = ($urandom % 4) != 0;
		mem_wd_i    = near_reg();
		mem_wdata_i = random_data();
		case ($urandom % 4)
			0:       ex_aluop_i = ALU_LW;
			1:       ex_aluop_i = ALU_SW;
			default: ex_aluop_i = ALU_ADD;
		endcase
	endtask

	task automatic predict_cycle();
		dec_t        d;
		br_t         b;
		logic [32:0] op1;
		logic [32:0] op2;
		d         = decode_inst(inst_i);
		op1       = resolve_operand(d.en1, inst_i[25:21], d.imm, reg1_data_i);
		op2       = resolve_operand(d.en2, inst_i[20:16], d.imm, reg2_data_i);
		b         = resolve_branch(pc_i, inst_i, d, op1[31:0], op2[31:0]);
		cap_stall = op1[32] | op2[32];
		check_value("decode", "reg1_addr_o", 32'(inst_i[25:21]), 32'(reg1_addr_o));
		check_value("decode", "reg2_addr_o", 32'(inst_i[20:16]), 32'(reg2_addr_o));
		check_value("load_use", "stall_o", 32'(cap_stall), 32'(stall_o));
		if (cap_stall) begin
			load_bubble();
		end else begin
			exp_aluop  = d.aluop;
			exp_alusel = class_of(d.aluop);
			exp_reg1   = op1[31:0];
			exp_reg2   = op2[31:0];
			exp_wd     = d.wd;
			exp_wreg   = b.wreg;
			exp_link   = b.link;
			exp_target = b.target;
			exp_flag   = b.taken;
			exp_inst   = inst_i;
			exp_ds     = prev_taken;
			prev_taken = b.taken;
		end
	endtask

	initial begin
		arst_n_i    = 1'b0;
		pc_i        = '0;
		inst_i      = '0;
		reg1_data_i = '0;
		reg2_data_i = '0;
		ex_wreg_i   = 1'b0;
		ex_wd_i     = '0;
		ex_wdata_i  = '0;
		ex_aluop_i  = ALU_NOP;
		mem_wreg_i  = 1'b0;
		mem_wd_i    = '0;
		mem_wdata_i = '0;
		cap_stall   = 1'b0;
		prev_taken  = 1'b0;
		exp_ds      = 1'b0;
		load_bubble();
		void'($urandom(32'h50db_d621));
		repeat (RESET_CYCLES) @(posedge clk_i);
		#1;
		check_registered("reset", "reset", "reset");
		arst_n_i = 1'b1;
		#1;
		check_registered("reset", "reset", "reset");
		for (int n = 0; n < RAND_CYCLES; n++) begin
			drive_random();
			#5;
			predict_cycle();
			@(posedge clk_i);
			#1;
			if (cap_stall)
				check_registered("load_use", "load_use", "load_use");
			else
				check_registered("decode", "bypass", "branch");
		end
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
